/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -Wno-fatal
TOP := sixAxisCtrlTb
FILELIST := sixAxisCtrl.f
OBJDIR := obj_dir
PASS_TEXT := Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

/* hw/hostRegs.sv */
`timescale 1ns/1ps

module hostRegs
	import motionPkg::*;
	import regMapPkg::*;
#(
	parameter int NUM_AXES = 6,
	parameter int GPOUT_WIDTH = 4
)
(
	input	logic								clk,
	input	logic								rst,
	input	logic								plbEn,
	input	logic								plbRd,
	input	logic								plbWr,
	input	logic			[31:0]				plbAddr,
	input	logic			[31:0]				plbWrData,
	output	logic								plbReady,
	output	logic			[31:0]				plbRdData,
	output	logic			[NUM_AXES-1:0]		prgmReq,
	output	logic			[NUM_AXES-1:0]		prgmForward,
	output	accelT			[NUM_AXES-1:0]		prgmAccel,
	output	sampleCountT	[NUM_AXES-1:0]		prgmAccelSamples,
	output	sampleCountT	[NUM_AXES-1:0]		prgmCruiseSamples,
	output	logic			[NUM_AXES-1:0]		setEnable,
	output	positionT		[NUM_AXES-1:0]		setPosition,
	output	limitT			[NUM_AXES-1:0]		limitLo,
	output	limitT			[NUM_AXES-1:0]		limitHi,
	output	logic			[NUM_AXES-1:0]		alarmClear,
	input	logic			[NUM_AXES-1:0]		prgmAck,
	input	logic			[NUM_AXES-1:0]		busy,
	input	logic			[NUM_AXES-1:0]		alarm,
	input	positionT		[NUM_AXES-1:0]		position,
	output	logic			[GPOUT_WIDTH-1:0]	gpout
);

	localparam int WORD_BITS = WORD_ADDR_MSB - WORD_ADDR_LSB + 1;

	logic [WORD_BITS-1:0] wordAddr;
	logic [WORD_BITS-OFFSET_BITS-1:0] axisIdx;
	regOffsetT offset;
	logic isGpout;
	logic wrStrobe;
	logic rdStrobe;
	logic [NUM_AXES-1:0] axisWr;
	logic [NUM_AXES-1:0] ctrlWrOk;
	logic [31:0] readWord;

	// --------------------------------------------------
	// address decode

	assign wordAddr = plbAddr[WORD_ADDR_MSB:WORD_ADDR_LSB];
	assign axisIdx = wordAddr[WORD_BITS-1:OFFSET_BITS];
	assign offset = regOffsetT'(wordAddr[OFFSET_BITS-1:0]);
	assign isGpout = (wordAddr == WORD_BITS'(GPOUT_WORD));
	assign wrStrobe = plbEn && plbWr;
	assign rdStrobe = plbEn && plbRd;

	// a pending start counts as busy, both for status and for new starts
	always_comb
	begin
		readWord = '0;
		if (isGpout)
			readWord[GPOUT_WIDTH-1:0] = gpout;
		for (int n = 0; n < NUM_AXES; n++)
		begin
			axisWr[n] = wrStrobe && (axisIdx == n);
			ctrlWrOk[n] = axisWr[n] && (offset == REG_CONTROL) && !busy[n] && !prgmReq[n];
			if (axisIdx == n)
			begin
				case (offset)
					REG_CONTROL: readWord[CTRL_FORWARD_BIT] = prgmForward[n];
					REG_ACCEL: readWord = prgmAccel[n];
					REG_ACCEL_SAMPLES: readWord = prgmAccelSamples[n];
					REG_CRUISE_SAMPLES: readWord = prgmCruiseSamples[n];
					REG_LIMITS:
					begin
						readWord[POSITION_WIDTH-1:0] = limitLo[n];
						readWord[LIMIT_HI_LSB +: POSITION_WIDTH] = limitHi[n];
					end
					REG_POSITION: readWord = 32'($signed(position[n]));
					REG_STATUS:
					begin
						readWord[STATUS_BUSY_BIT] = busy[n] || prgmReq[n];
						readWord[STATUS_ALARM_BIT] = alarm[n];
					end
					default: readWord = '0;
				endcase
			end
		end
	end

	// --------------------------------------------------
	// bus response, strobes and control registers

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			plbReady <= 1'b0;
			plbRdData <= '0;
			gpout <= '0;
			prgmReq <= '0;
			setEnable <= '0;
			alarmClear <= '0;
			for (int n = 0; n < NUM_AXES; n++)
			begin
				limitLo[n] <= LIMIT_MIN;
				limitHi[n] <= LIMIT_MAX;
			end
		end
		else
		begin
			plbReady <= plbEn;
			plbRdData <= rdStrobe ? readWord : '0;
			if (wrStrobe && isGpout)
				gpout <= plbWrData[GPOUT_WIDTH-1:0];
			for (int n = 0; n < NUM_AXES; n++)
			begin
				setEnable[n] <= axisWr[n] && (offset == REG_POSITION);
				alarmClear[n] <= axisWr[n] && (offset == REG_STATUS)
					&& plbWrData[STATUS_ALARM_BIT];
				if (prgmAck[n])
					prgmReq[n] <= 1'b0;
				else if (ctrlWrOk[n] && plbWrData[CTRL_START_BIT])
					prgmReq[n] <= 1'b1;
				if (axisWr[n] && (offset == REG_LIMITS))
				begin
					limitLo[n] <= plbWrData[POSITION_WIDTH-1:0];
					limitHi[n] <= plbWrData[LIMIT_HI_LSB +: POSITION_WIDTH];
				end
			end
		end
	end

	// move parameters, taken by the axis on prgmAck
	always_ff @(posedge clk)
	begin
		for (int n = 0; n < NUM_AXES; n++)
		begin
			if (ctrlWrOk[n])
				prgmForward[n] <= plbWrData[CTRL_FORWARD_BIT];
			if (axisWr[n])
			begin
				case (offset)
					REG_ACCEL: prgmAccel[n] <= accelT'(plbWrData);
					REG_ACCEL_SAMPLES: prgmAccelSamples[n] <= plbWrData;
					REG_CRUISE_SAMPLES: prgmCruiseSamples[n] <= plbWrData;
					REG_POSITION: setPosition[n] <= plbWrData[POSITION_WIDTH-1:0];
					default:
					begin
					end
				endcase
			end
		end
	end

endmodule

/* hw/motionPkg.sv */
package motionPkg;

	// axis widths
	localparam int POSITION_WIDTH = 16;
	localparam int ACCUM_WIDTH = 32;
	localparam int PHASE_COUNT_WIDTH = 16;

	// motor position and travel limits, in steps
	typedef logic signed [POSITION_WIDTH-1:0] positionT;
	typedef logic signed [POSITION_WIDTH-1:0] limitT;

	// velocity change applied once per tick
	typedef logic signed [ACCUM_WIDTH-1:0] accelT;

	// step rate, one full accumulator wrap is one step
	typedef logic [ACCUM_WIDTH-1:0] velocityT;

	// length of a profile segment in ticks
	typedef logic [31:0] sampleCountT;

	// full travel range
	localparam limitT LIMIT_MIN = {1'b1, {(POSITION_WIDTH-1){1'b0}}};
	localparam limitT LIMIT_MAX = {1'b0, {(POSITION_WIDTH-1){1'b1}}};

	// trapezoid segments
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		ACCEL = 2'd1,
		CRUISE = 2'd2,
		DECEL = 2'd3
	} profileStateT;

endpackage

/* hw/phaseGen.sv */
`timescale 1ns/1ps

module phaseGen
	import motionPkg::*;
#(
	parameter int PHASE_PERIOD = 200
)
(
	input	logic	clk,
	input	logic	rst,
	output	logic	ph1,
	output	logic	ph2,
	output	logic	ph3,
	output	logic	ph4
);

	logic [PHASE_COUNT_WIDTH-1:0] phaseCount;

	// period counter with one strobe per count 0..3, delayed by a register
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			phaseCount <= '0;
			ph1 <= 1'b0;
			ph2 <= 1'b0;
			ph3 <= 1'b0;
			ph4 <= 1'b0;
		end
		else
		begin
			if (phaseCount == PHASE_COUNT_WIDTH'(PHASE_PERIOD - 1))
				phaseCount <= '0;
			else
				phaseCount <= phaseCount + PHASE_COUNT_WIDTH'(1);
			ph1 <= (phaseCount == PHASE_COUNT_WIDTH'(0));
			ph2 <= (phaseCount == PHASE_COUNT_WIDTH'(1));
			ph3 <= (phaseCount == PHASE_COUNT_WIDTH'(2));
			ph4 <= (phaseCount == PHASE_COUNT_WIDTH'(3));
		end
	end

endmodule

/* hw/profileGen.sv */
`timescale 1ns/1ps

module profileGen
	import motionPkg::*;
(
	input	logic			clk,
	input	logic			rst,
	input	logic			ph1,
	input	logic			ph2,
	input	logic			prgmReq,
	input	logic			prgmForward,
	input	accelT			prgmAccel,
	input	sampleCountT	prgmAccelSamples,
	input	sampleCountT	prgmCruiseSamples,
	output	logic			prgmAck,
	output	logic			busy,
	output	logic			stepStrobe,
	output	logic			stepDir
);

	profileStateT state;
	sampleCountT ticksLeft;
	logic lastTick;
	velocityT velocity;
	velocityT accum;
	logic [ACCUM_WIDTH:0] accumSum;

	// move parameters captured at the start of a move
	accelT moveAccel;
	sampleCountT moveAccelSamples;
	sampleCountT moveCruiseSamples;

	// a request is taken on the first ph1 seen while idle
	assign prgmAck = ph1 && prgmReq && (state == IDLE);
	assign busy = (state != IDLE);
	assign lastTick = (ticksLeft == sampleCountT'(1));
	assign accumSum = {1'b0, accum} + {1'b0, velocity};

	// --------------------------------------------------
	// velocity profile

	always_ff @(posedge clk)
	begin
		if (prgmAck)
		begin
			moveAccel <= prgmAccel;
			moveAccelSamples <= prgmAccelSamples;
			moveCruiseSamples <= prgmCruiseSamples;
		end
	end

	// the last tick of a segment already moves on, so every ph1 is a real tick
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			ticksLeft <= '0;
			velocity <= '0;
			stepDir <= 1'b0;
		end
		else if (prgmAck)
		begin
			velocity <= '0;
			stepDir <= prgmForward;
			if (prgmAccelSamples != '0)
			begin
				state <= ACCEL;
				ticksLeft <= prgmAccelSamples;
			end
			else if (prgmCruiseSamples != '0)
			begin
				state <= CRUISE;
				ticksLeft <= prgmCruiseSamples;
			end
			else
				state <= IDLE;
		end
		else if (ph1)
		begin
			case (state)
				ACCEL:
				begin
					velocity <= velocity + velocityT'(moveAccel);
					if (!lastTick)
						ticksLeft <= ticksLeft - sampleCountT'(1);
					else if (moveCruiseSamples != '0)
					begin
						state <= CRUISE;
						ticksLeft <= moveCruiseSamples;
					end
					else
					begin
						state <= DECEL;
						ticksLeft <= moveAccelSamples;
					end
				end
				CRUISE:
				begin
					if (!lastTick)
						ticksLeft <= ticksLeft - sampleCountT'(1);
					else if (moveAccelSamples != '0)
					begin
						state <= DECEL;
						ticksLeft <= moveAccelSamples;
					end
					else
						state <= IDLE;
				end
				DECEL:
				begin
					velocity <= velocity - velocityT'(moveAccel);
					if (!lastTick)
						ticksLeft <= ticksLeft - sampleCountT'(1);
					else
						state <= IDLE;
				end
				default:
				begin
				end
			endcase
		end
	end

	// --------------------------------------------------
	// step accumulator, carry out is one step

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			accum <= '0;
			stepStrobe <= 1'b0;
		end
		else
		begin
			if (prgmAck)
				accum <= '0;
			else if (ph2)
				accum <= accumSum[ACCUM_WIDTH-1:0];
			stepStrobe <= ph2 && accumSum[ACCUM_WIDTH];
		end
	end

endmodule

/* hw/regMapPkg.sv */
package regMapPkg;

	// address split, word address is taken from byte address bits 9:2
	localparam int WORD_ADDR_MSB = 9;
	localparam int WORD_ADDR_LSB = 2;
	localparam int AXIS_BLOCK_WORDS = 8;
	localparam int OFFSET_BITS = $clog2(AXIS_BLOCK_WORDS);

	// word offsets inside one axis block
	typedef enum logic [OFFSET_BITS-1:0] {
		REG_CONTROL = 3'd0,
		REG_ACCEL = 3'd1,
		REG_ACCEL_SAMPLES = 3'd2,
		REG_CRUISE_SAMPLES = 3'd3,
		REG_LIMITS = 3'd4,
		REG_POSITION = 3'd5,
		REG_STATUS = 3'd6
	} regOffsetT;

	// global registers sit above all axis blocks
	localparam int GLOBAL_BASE = 64;
	localparam int GPOUT_WORD = GLOBAL_BASE;

	// field positions
	localparam int CTRL_START_BIT = 0;
	localparam int CTRL_FORWARD_BIT = 1;
	localparam int LIMIT_HI_LSB = 16;
	localparam int STATUS_BUSY_BIT = 0;
	localparam int STATUS_ALARM_BIT = 1;

endpackage

/* hw/sixAxisCtrl.sv */
`timescale 1ns/1ps

module sixAxisCtrl
	import motionPkg::*;
#(
	parameter int NUM_AXES = 6,
	parameter int PHASE_PERIOD = 200,
	parameter int GPOUT_WIDTH = 4
)
(
	input	logic						clk,
	input	logic						rst,
	input	logic						plbEn,
	input	logic						plbRd,
	input	logic						plbWr,
	input	logic	[31:0]				plbAddr,
	input	logic	[31:0]				plbWrData,
	output	logic						plbReady,
	output	logic	[31:0]				plbRdData,
	output	logic	[NUM_AXES-1:0]		mAlarm,
	output	logic	[NUM_AXES-1:0]		mDir,
	output	logic	[NUM_AXES-1:0]		mStep,
	output	logic	[GPOUT_WIDTH-1:0]	gpout
);

	logic ph1;
	logic ph2;

	logic [NUM_AXES-1:0] prgmReq;
	logic [NUM_AXES-1:0] prgmAck;
	logic [NUM_AXES-1:0] prgmForward;
	accelT [NUM_AXES-1:0] prgmAccel;
	sampleCountT [NUM_AXES-1:0] prgmAccelSamples;
	sampleCountT [NUM_AXES-1:0] prgmCruiseSamples;
	logic [NUM_AXES-1:0] busy;
	logic [NUM_AXES-1:0] setEnable;
	positionT [NUM_AXES-1:0] setPosition;
	limitT [NUM_AXES-1:0] limitLo;
	limitT [NUM_AXES-1:0] limitHi;
	logic [NUM_AXES-1:0] alarmClear;
	positionT [NUM_AXES-1:0] position;
	logic [NUM_AXES-1:0] stepStrobe;
	logic [NUM_AXES-1:0] stepDir;

	// ph3 and ph4 are spare phases
	phaseGen #(
		.PHASE_PERIOD		(PHASE_PERIOD)
	) phases (
		.clk				(clk),
		.rst				(rst),
		.ph1				(ph1),
		.ph2				(ph2),
		.ph3				(),
		.ph4				()
	);

	hostRegs #(
		.NUM_AXES			(NUM_AXES),
		.GPOUT_WIDTH		(GPOUT_WIDTH)
	) regs (
		.clk				(clk),
		.rst				(rst),
		.plbEn				(plbEn),
		.plbRd				(plbRd),
		.plbWr				(plbWr),
		.plbAddr			(plbAddr),
		.plbWrData			(plbWrData),
		.plbReady			(plbReady),
		.plbRdData			(plbRdData),
		.prgmReq			(prgmReq),
		.prgmForward		(prgmForward),
		.prgmAccel			(prgmAccel),
		.prgmAccelSamples	(prgmAccelSamples),
		.prgmCruiseSamples	(prgmCruiseSamples),
		.setEnable			(setEnable),
		.setPosition		(setPosition),
		.limitLo			(limitLo),
		.limitHi			(limitHi),
		.alarmClear			(alarmClear),
		.prgmAck			(prgmAck),
		.busy				(busy),
		.alarm				(mAlarm),
		.position			(position),
		.gpout				(gpout)
	);

	// --------------------------------------------------
	// one profile generator and limiter per axis

	for (genvar n = 0; n < NUM_AXES; n++)
	begin : gAxis
		profileGen profile (
			.clk				(clk),
			.rst				(rst),
			.ph1				(ph1),
			.ph2				(ph2),
			.prgmReq			(prgmReq[n]),
			.prgmForward		(prgmForward[n]),
			.prgmAccel			(prgmAccel[n]),
			.prgmAccelSamples	(prgmAccelSamples[n]),
			.prgmCruiseSamples	(prgmCruiseSamples[n]),
			.prgmAck			(prgmAck[n]),
			.busy				(busy[n]),
			.stepStrobe			(stepStrobe[n]),
			.stepDir			(stepDir[n])
		);

		travelLimiter limiter (
			.clk				(clk),
			.rst				(rst),
			.stepStrobe			(stepStrobe[n]),
			.stepDir			(stepDir[n]),
			.setEnable			(setEnable[n]),
			.alarmClear			(alarmClear[n]),
			.setPosition		(setPosition[n]),
			.limitLo			(limitLo[n]),
			.limitHi			(limitHi[n]),
			.mStep				(mStep[n]),
			.mDir				(mDir[n]),
			.alarm				(mAlarm[n]),
			.position			(position[n])
		);
	end

endmodule

/* hw/travelLimiter.sv */
`timescale 1ns/1ps

module travelLimiter
	import motionPkg::*;
(
	input	logic		clk,
	input	logic		rst,
	input	logic		stepStrobe,
	input	logic		stepDir,
	input	logic		setEnable,
	input	logic		alarmClear,
	input	positionT	setPosition,
	input	limitT		limitLo,
	input	limitT		limitHi,
	output	logic		mStep,
	output	logic		mDir,
	output	logic		alarm,
	output	positionT	position
);

	logic atHiLimit;
	logic atLoLimit;
	logic limitHit;
	logic stepPass;

	// stepDir high is forward
	assign atHiLimit = (position == limitHi) && stepDir;
	assign atLoLimit = (position == limitLo) && !stepDir;
	assign limitHit = stepStrobe && (atHiLimit || atLoLimit);

	// no steps at all while the alarm is latched
	assign stepPass = stepStrobe && !alarm && !atHiLimit && !atLoLimit;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			mStep <= 1'b0;
			mDir <= 1'b0;
			alarm <= 1'b0;
			position <= '0;
		end
		else
		begin
			mStep <= stepPass;
			mDir <= stepDir;

			// a blocked step wins over a clear in the same cycle
			if (limitHit)
				alarm <= 1'b1;
			else if (alarmClear)
				alarm <= 1'b0;

			if (setEnable)
				position <= setPosition;
			else if (stepPass)
			begin
				if (stepDir)
					position <= position + positionT'(1);
				else
					position <= position - positionT'(1);
			end
		end
	end

endmodule

/* sim/sixAxisCtrlTb.sv */
`timescale 1ns/1ps

module sixAxisCtrlTb
	import motionPkg::*;
	import regMapPkg::*;
;

	localparam int NUM_AXES = 6;
	localparam int GPOUT_WIDTH = 4;
	localparam int NUM_ROWS = 8;
	localparam int BUS_TIMEOUT = 8;
	localparam int DONE_POLLS = 2000;
	localparam int STEP_TIMEOUT = 1000;

	logic clk;
	logic rst;
	logic plbEn;
	logic plbRd;
	logic plbWr;
	logic [31:0] plbAddr;
	logic [31:0] plbWrData;
	logic plbReady;
	logic [31:0] plbRdData;
	logic [NUM_AXES-1:0] mAlarm;
	logic [NUM_AXES-1:0] mDir;
	logic [NUM_AXES-1:0] mStep;
	logic [GPOUT_WIDTH-1:0] gpout;

	int checkCount;
	int errorCount;
	int timeoutCount;
	logic [31:0] lfsrState = 32'h1bdb20e6;

	// step monitor totals per axis
	int stepCount[NUM_AXES];
	int fwdCount[NUM_AXES];

	// move table
	string rowName[NUM_ROWS];
	int rowAxis[NUM_ROWS];
	logic rowFwd[NUM_ROWS];
	accelT rowAccel[NUM_ROWS];
	int rowAccelTicks[NUM_ROWS];
	int rowCruiseTicks[NUM_ROWS];
	int rowLo[NUM_ROWS];
	int rowHi[NUM_ROWS];
	int rowStart[NUM_ROWS];
	logic rowLoad[NUM_ROWS];
	logic rowClear[NUM_ROWS];
	logic rowBusyStart[NUM_ROWS];
	logic rowChain[NUM_ROWS];
	logic rowExpAlarm[NUM_ROWS];

	// expected results and monitor baselines per row
	int rowExpSteps[NUM_ROWS];
	positionT rowExpPos[NUM_ROWS];
	int baseStep[NUM_ROWS];
	int baseFwd[NUM_ROWS];
	positionT modelPos[NUM_AXES];
	logic modelAlarm[NUM_AXES];
	int pending[$];

	sixAxisCtrl #(
		.NUM_AXES		(NUM_AXES),
		.PHASE_PERIOD	(16),
		.GPOUT_WIDTH	(GPOUT_WIDTH)
	) DUT (
		.clk			(clk),
		.rst			(rst),
		.plbEn			(plbEn),
		.plbRd			(plbRd),
		.plbWr			(plbWr),
		.plbAddr		(plbAddr),
		.plbWrData		(plbWrData),
		.plbReady		(plbReady),
		.plbRdData		(plbRdData),
		.mAlarm			(mAlarm),
		.mDir			(mDir),
		.mStep			(mStep),
		.gpout			(gpout)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// count motor steps and the ones taken with mDir high
	always @(negedge clk)
	begin
		for (int n = 0; n < NUM_AXES; n++)
		begin
			if (mStep[n] === 1'b1)
			begin
				stepCount[n]++;
				if (mDir[n] === 1'b1)
					fwdCount[n]++;
			end
		end
	end

	// --------------------------------------------------
	// helpers

	// taps of x^32 + x^22 + x^2 + x + 1
	// one shift per bit taken
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		logic feedback;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	function automatic logic [31:0] regAddr(input int axis, input regOffsetT offset);
		return 32'((axis * AXIS_BLOCK_WORDS + int'(offset)) * 4);
	endfunction

	// sum of per-tick velocities over 2^32 gives the step count
	function automatic int expectedSteps(input longint accel, input int accelTicks,
		input int cruiseTicks);
		longint velocity;
		longint total;
		velocity = 0;
		total = 0;
		for (int i = 0; i < accelTicks; i++)
		begin
			velocity += accel;
			total += velocity;
		end
		for (int i = 0; i < cruiseTicks; i++)
			total += velocity;
		for (int i = 0; i < accelTicks; i++)
		begin
			velocity -= accel;
			total += velocity;
		end
		return int'(total >>> 32);
	endfunction

	task automatic compareInt(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (expected !== actual)
		begin
			$display("CHECK FAILED %s: expected %0d (0x%08h), actual %0d (0x%08h)",
				name, expected, expected, actual, actual);
			errorCount++;
		end
	endtask

	task automatic compareBit(input string name, input logic expected, input logic actual);
		checkCount++;
		if (expected !== actual)
		begin
			$display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic comparePosition(input string name, input positionT expected,
		input positionT actual);
		checkCount++;
		if (expected !== actual)
		begin
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
			errorCount++;
		end
	endtask

	// --------------------------------------------------
	// bus access

	task automatic busWrite(input logic [31:0] addr, input logic [31:0] data);
		int waited;
		@(negedge clk);
		plbEn = 1'b1;
		plbWr = 1'b1;
		plbAddr = addr;
		plbWrData = data;
		@(negedge clk);
		plbEn = 1'b0;
		plbWr = 1'b0;
		waited = 0;
		while (!plbReady && waited < BUS_TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!plbReady)
		begin
			$display("bus write to 0x%08h never got plbReady", addr);
			timeoutCount++;
		end
	endtask

	task automatic busRead(input logic [31:0] addr, output logic [31:0] data);
		int waited;
		@(negedge clk);
		plbEn = 1'b1;
		plbRd = 1'b1;
		plbAddr = addr;
		@(negedge clk);
		plbEn = 1'b0;
		plbRd = 1'b0;
		waited = 0;
		while (!plbReady && waited < BUS_TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!plbReady)
		begin
			$display("bus read of 0x%08h never got plbReady", addr);
			timeoutCount++;
			data = '0;
		end
		else
			data = plbRdData;
	endtask

	task automatic waitIdle(input int axis, input string name);
		logic [31:0] status;
		int polls;
		polls = 0;
		busRead(regAddr(axis, REG_STATUS), status);
		while (status[STATUS_BUSY_BIT] && polls < DONE_POLLS)
		begin
			busRead(regAddr(axis, REG_STATUS), status);
			polls++;
		end
		if (status[STATUS_BUSY_BIT])
		begin
			$display("%s: axis %0d still busy after %0d status polls", name, axis, polls);
			timeoutCount++;
		end
	endtask

	// --------------------------------------------------
	// move table and its application

	task automatic setRow(input int r, input string name, input int axis, input logic fwd,
		input accelT accel, input int accelTicks, input int cruiseTicks,
		input int lo, input int hi, input int start, input logic load, input logic clear,
		input logic busyStart, input logic chain, input logic expAlarm);
		rowName[r] = name;
		rowAxis[r] = axis;
		rowFwd[r] = fwd;
		rowAccel[r] = accel;
		rowAccelTicks[r] = accelTicks;
		rowCruiseTicks[r] = cruiseTicks;
		rowLo[r] = lo;
		rowHi[r] = hi;
		rowStart[r] = start;
		rowLoad[r] = load;
		rowClear[r] = clear;
		rowBusyStart[r] = busyStart;
		rowChain[r] = chain;
		rowExpAlarm[r] = expAlarm;
	endtask

	task automatic startMove(input int r);
		int axis;
		int steps;
		int room;
		int waited;
		accelT accel;
		axis = rowAxis[r];
		accel = rowAccel[r] + accelT'(randomBits(16));
		if (rowClear[r])
		begin
			busWrite(regAddr(axis, REG_STATUS), 32'(1) << STATUS_ALARM_BIT);
			modelAlarm[axis] = 1'b0;
		end
		busWrite(regAddr(axis, REG_LIMITS), {rowHi[r][15:0], rowLo[r][15:0]});
		busWrite(regAddr(axis, REG_ACCEL), accel);
		busWrite(regAddr(axis, REG_ACCEL_SAMPLES), rowAccelTicks[r]);
		busWrite(regAddr(axis, REG_CRUISE_SAMPLES), rowCruiseTicks[r]);
		if (rowLoad[r])
		begin
			busWrite(regAddr(axis, REG_POSITION), rowStart[r]);
			modelPos[axis] = positionT'(rowStart[r]);
		end

		// expected count clipped at the limit in the move direction
		steps = modelAlarm[axis] ? 0 :
			expectedSteps(longint'(accel), rowAccelTicks[r], rowCruiseTicks[r]);
		if (rowFwd[r])
			room = rowHi[r] - int'(modelPos[axis]);
		else
			room = int'(modelPos[axis]) - rowLo[r];
		if (steps > room)
			steps = room;
		rowExpSteps[r] = steps;
		rowExpPos[r] = rowFwd[r] ? modelPos[axis] + positionT'(steps) :
			modelPos[axis] - positionT'(steps);
		modelPos[axis] = rowExpPos[r];
		modelAlarm[axis] = rowExpAlarm[r];

		baseStep[r] = stepCount[axis];
		baseFwd[r] = fwdCount[axis];
		busWrite(regAddr(axis, REG_CONTROL), {30'd0, rowFwd[r], 1'b1});

		// a second start in reverse once the move is stepping
		if (rowBusyStart[r])
		begin
			waited = 0;
			while (stepCount[axis] == baseStep[r] && waited < STEP_TIMEOUT)
			begin
				@(negedge clk);
				waited++;
			end
			if (stepCount[axis] == baseStep[r])
			begin
				$display("%s: axis %0d made no step before the second start", rowName[r], axis);
				timeoutCount++;
			end
			busWrite(regAddr(axis, REG_CONTROL), 32'h1);
		end
	endtask

	task automatic finishMove(input int r);
		logic [31:0] rd;
		int axis;
		axis = rowAxis[r];
		waitIdle(axis, rowName[r]);
		compareInt({rowName[r], " steps"}, rowExpSteps[r], stepCount[axis] - baseStep[r]);
		compareInt({rowName[r], " steps with mDir high"}, rowFwd[r] ? rowExpSteps[r] : 0,
			fwdCount[axis] - baseFwd[r]);
		busRead(regAddr(axis, REG_POSITION), rd);
		comparePosition({rowName[r], " position"}, rowExpPos[r], positionT'(rd[15:0]));
		compareBit({rowName[r], " mAlarm"}, rowExpAlarm[r], mAlarm[axis]);
		busRead(regAddr(axis, REG_STATUS), rd);
		compareBit({rowName[r], " status alarm"}, rowExpAlarm[r], rd[STATUS_ALARM_BIT]);
		compareBit({rowName[r], " status busy"}, 1'b0, rd[STATUS_BUSY_BIT]);
	endtask

	// --------------------------------------------------
	// main sequence

	initial
	begin
		logic [31:0] data;
		logic [31:0] rd;
		regOffsetT offset;

		rst = 1'b1;
		plbEn = 1'b0;
		plbRd = 1'b0;
		plbWr = 1'b0;
		plbAddr = '0;
		plbWrData = '0;
		for (int n = 0; n < NUM_AXES; n++)
		begin
			modelPos[n] = '0;
			modelAlarm[n] = 1'b0;
		end

		setRow(0, "forward move", 0, 1'b1, 32'h1000_0000, 10, 10, -32768, 32767, 0,
			1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
		setRow(1, "reverse move", 1, 1'b0, 32'h0C00_0000, 8, 20, -32768, 32767, 100,
			1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
		setRow(2, "back to back first", 2, 1'b1, 32'h0800_0000, 12, 6, -32768, 32767, -50,
			1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
		setRow(3, "back to back second", 3, 1'b0, 32'h1400_0000, 6, 12, -32768, 32767, 0,
			1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
		setRow(4, "high limit stop", 4, 1'b1, 32'h1000_0000, 10, 10, -100, 5, 0,
			1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
		setRow(5, "alarm blocks steps", 4, 1'b0, 32'h1000_0000, 10, 10, -100, 5, 0,
			1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
		setRow(6, "alarm cleared", 4, 1'b0, 32'h1000_0000, 10, 10, -100, 5, 0,
			1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
		setRow(7, "start while busy", 5, 1'b1, 32'h1000_0000, 10, 10, -32768, 32767, 0,
			1'b1, 1'b0, 1'b1, 1'b0, 1'b0);

		repeat (16) @(negedge clk);
		rst = 1'b0;
		repeat (2) @(negedge clk);

		// idle outputs after reset
		compareInt("reset mStep", 0, mStep);
		compareInt("reset mAlarm", 0, mAlarm);
		compareInt("reset gpout", 0, gpout);
		compareBit("reset plbReady", 1'b0, plbReady);
		for (int n = 0; n < NUM_AXES; n++)
		begin
			busRead(regAddr(n, REG_STATUS), rd);
			compareInt($sformatf("reset status axis %0d", n), 0, rd);
		end

		// register readback from REG_ACCEL up to REG_LIMITS
		for (int n = 0; n < NUM_AXES; n++)
		begin
			for (int k = 1; k <= 4; k++)
			begin
				offset = regOffsetT'(k);
				data = randomBits(32);
				busWrite(regAddr(n, offset), data);
				busRead(regAddr(n, offset), rd);
				compareInt($sformatf("readback axis %0d %s", n, offset.name()), data, rd);
			end
		end
		data = randomBits(32);
		busWrite(32'(GPOUT_WORD * 4), data);
		busRead(32'(GPOUT_WORD * 4), rd);
		compareInt("gpout readback", int'(data[GPOUT_WIDTH-1:0]), rd);
		compareInt("gpout port", int'(data[GPOUT_WIDTH-1:0]), gpout);

		// chained rows are checked together with the next unchained one
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			startMove(r);
			pending.push_back(r);
			if (!rowChain[r])
			begin
				while (pending.size() > 0)
					finishMove(pending.pop_front());
			end
		end

		$display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* sixAxisCtrl.f */
hw/motionPkg.sv
hw/regMapPkg.sv
hw/phaseGen.sv
hw/profileGen.sv
hw/travelLimiter.sv
hw/hostRegs.sv
hw/sixAxisCtrl.sv
sim/sixAxisCtrlTb.sv
